//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sp605_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/apb_decoder.sv
`timescale 1ns/10ps

module apb_decoder (
    apb_if.slave  host,
    apb_if.master page0
);
    import core_pkg::*;

    logic page0_hit;
    logic null_ready;

    assign page0_hit = apb_page_t'(host.addr[19:12]) == page_int_regs;

    assign page0.sel    = host.sel && page0_hit;
    assign page0.enable = host.enable;
    assign page0.write  = host.write;
    assign page0.addr   = host.addr;
    assign page0.wdata  = host.wdata;
    assign page0.strb   = host.strb;

    // Null slave, done in the first access cycle
    assign null_ready = host.sel && host.enable && !page0_hit;

    assign host.ready  = page0_hit ? page0.ready : null_ready;
    assign host.rdata  = page0_hit ? page0.rdata : '0;  // Unmapped pages read zero
    assign host.slverr = page0_hit && page0.slverr;

endmodule

//--- hdl/apb_if.sv
`timescale 1ns/10ps

interface apb_if #(
    parameter int ADDR = 32
);
    import core_pkg::*;

    logic            sel;
    logic            enable;
    logic            write;
    logic [ADDR-1:0] addr;
    data_t           wdata;
    strb_t           strb;
    logic            ready;
    data_t           rdata;
    logic            slverr;

    modport master (
        output sel, enable, write, addr, wdata, strb,
        input  ready, rdata, slverr
    );

    modport slave (
        input  sel, enable, write, addr, wdata, strb,
        output ready, rdata, slverr
    );

endinterface

//--- hdl/axi_lite_if.sv
`timescale 1ns/10ps

interface axi_lite_if #(
    parameter int ADDR = 32
);
    import core_pkg::*;

    logic            ar_valid;
    logic            ar_ready;
    logic [ADDR-1:0] ar_addr;
    logic            r_valid;
    logic            r_ready;
    data_t           r_data;
    resp_t           r_resp;
    logic            aw_valid;
    logic            aw_ready;
    logic [ADDR-1:0] aw_addr;
    logic            w_valid;
    logic            w_ready;
    data_t           w_data;
    strb_t           w_strb;
    logic            b_valid;
    logic            b_ready;
    resp_t           b_resp;

    modport master (
        output ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        input  ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
    );

    modport slave (
        input  ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        output ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
    );

endinterface

//--- hdl/axi_to_apb.sv
`timescale 1ns/10ps

module axi_to_apb (
    input  logic      clk,
    input  logic      reset,
    axi_lite_if.slave bus,
    apb_if.master     apb
);
    import core_pkg::*;

    bridge_state_t state;
    data_t         rdata_q;
    logic          slverr_q;
    logic          wr_take;
    logic          rd_take;
    logic          resp_done;
    resp_t         resp;

    // Write wins over a read pending in the same cycle
    assign wr_take = state == st_idle && bus.aw_valid && bus.w_valid;
    assign rd_take = state == st_idle && bus.ar_valid && !(bus.aw_valid && bus.w_valid);

    assign bus.aw_ready = wr_take;
    assign bus.w_ready  = wr_take;
    assign bus.ar_ready = rd_take;

    assign apb.sel    = state == st_setup || state == st_access;
    assign apb.enable = state == st_access;

    assign resp        = slverr_q ? resp_slverr : resp_okay;
    assign bus.r_valid = state == st_resp && !apb.write;
    assign bus.b_valid = state == st_resp && apb.write;
    assign bus.r_data  = rdata_q;
    assign bus.r_resp  = resp;
    assign bus.b_resp  = resp;

    assign resp_done = (bus.r_valid && bus.r_ready) || (bus.b_valid && bus.b_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (wr_take || rd_take) state <= st_setup;
                st_setup:  state <= st_access;
                st_access: if (apb.ready) state <= st_resp;  // Wait states end here
                st_resp:   if (resp_done) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    // Request held from setup until ready
    always_ff @(posedge clk) begin
        if (wr_take) begin
            apb.addr  <= bus.aw_addr;
            apb.write <= 1'b1;
            apb.wdata <= bus.w_data;
            apb.strb  <= bus.w_strb;
        end else if (rd_take) begin
            apb.addr  <= bus.ar_addr;
            apb.write <= 1'b0;
            apb.strb  <= '0;
        end
        if (state == st_access && apb.ready) begin
            rdata_q  <= apb.rdata;
            slverr_q <= apb.slverr;
        end
    end

    // Request fields hold through access
    a_apb_stable: assert property (@(posedge clk) disable iff (reset)
        apb.enable |-> $stable(apb.addr) && $stable(apb.write)
                       && (!apb.write || $stable(apb.wdata)));

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // AXI response encoding
    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2,
        resp_decerr = 2'd3
    } resp_t;

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access,
        st_resp
    } bridge_state_t;

    // 4 KB pages, picked by addr[19:12]
    typedef enum logic [7:0] {
        page_int_regs = 8'd0
    } apb_page_t;

    localparam logic [31:0] DRAM_BASE = 32'h0000_0000;
    localparam logic [31:0] DRAM_MASK = 32'h07FF_FFFF;  // 128 MB
    localparam logic [31:0] REG_BASE  = 32'h8000_0000;
    localparam logic [31:0] REG_MASK  = 32'h000F_FFFF;  // 1 MB

    // Interrupt block, page 0
    localparam logic [11:0] INT_STATUS_OFS = 12'h000;
    localparam logic [11:0] INT_ENABLE_OFS = 12'h004;
    localparam logic [11:0] INT_RAW_OFS    = 12'h008;

endpackage

//--- hdl/ib_router.sv
`timescale 1ns/10ps

module ib_router #(
    parameter int ADDR = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                ib_ar_valid,
    output logic                ib_ar_ready,
    input  logic [ADDR-1:0]     ib_ar_addr,
    output logic                ib_r_valid,
    input  logic                ib_r_ready,
    output core_pkg::data_t     ib_r_data,
    output core_pkg::resp_t     ib_r_resp,
    input  logic                ib_aw_valid,
    output logic                ib_aw_ready,
    input  logic [ADDR-1:0]     ib_aw_addr,
    input  logic                ib_w_valid,
    output logic                ib_w_ready,
    input  core_pkg::data_t     ib_w_data,
    input  core_pkg::strb_t     ib_w_strb,
    output logic                ib_b_valid,
    input  logic                ib_b_ready,
    output core_pkg::resp_t     ib_b_resp,
    output logic                dram_ar_valid,
    input  logic                dram_ar_ready,
    output logic [ADDR-1:0]     dram_ar_addr,
    input  logic                dram_r_valid,
    output logic                dram_r_ready,
    input  core_pkg::data_t     dram_r_data,
    input  core_pkg::resp_t     dram_r_resp,
    output logic                dram_aw_valid,
    input  logic                dram_aw_ready,
    output logic [ADDR-1:0]     dram_aw_addr,
    output logic                dram_w_valid,
    input  logic                dram_w_ready,
    output core_pkg::data_t     dram_w_data,
    output core_pkg::strb_t     dram_w_strb,
    input  logic                dram_b_valid,
    output logic                dram_b_ready,
    input  core_pkg::resp_t     dram_b_resp,
    axi_lite_if.master          reg_bus
);
    import core_pkg::*;

    typedef enum logic [1:0] {dest_dram, dest_reg, dest_err} dest_t;

    logic            ar_hs, r_hs, aw_hs, b_hs;
    logic            rd_busy, wr_busy, wr_ready;
    dest_t           rd_dest, wr_dest, rd_hit, wr_hit;
    logic [ADDR-1:0] rd_addr, wr_addr;
    data_t           wr_data;
    strb_t           wr_strb;
    logic            fwd_r_valid, fwd_r_ready, fwd_b_valid, fwd_b_ready;
    data_t           fwd_r_data;
    resp_t           fwd_r_resp, fwd_b_resp;

    function automatic dest_t decode(input logic [ADDR-1:0] addr);
        if ((addr & ~ADDR'(DRAM_MASK)) == ADDR'(DRAM_BASE))
            return dest_dram;
        if ((addr & ~ADDR'(REG_MASK)) == ADDR'(REG_BASE))
            return dest_reg;
        return dest_err;
    endfunction

    assign rd_hit = decode(ib_ar_addr);
    assign wr_hit = decode(ib_aw_addr);
    assign ar_hs  = ib_ar_valid && ib_ar_ready;
    assign r_hs   = ib_r_valid && ib_r_ready;
    assign aw_hs  = ib_aw_valid && ib_w_valid && wr_ready;  // address and data together
    assign b_hs   = ib_b_valid && ib_b_ready;

    assign ib_aw_ready = wr_ready;
    assign ib_w_ready  = wr_ready;

    assign dram_ar_addr    = rd_addr;
    assign reg_bus.ar_addr = rd_addr;
    assign dram_aw_addr    = wr_addr;
    assign reg_bus.aw_addr = wr_addr;
    assign dram_w_data     = wr_data;
    assign reg_bus.w_data  = wr_data;
    assign dram_w_strb     = wr_strb;
    assign reg_bus.w_strb  = wr_strb;

    // Response from the selected destination
    always_comb begin
        fwd_r_valid = rd_dest == dest_dram ? dram_r_valid : rd_dest == dest_reg && reg_bus.r_valid;
        fwd_r_data  = rd_dest == dest_dram ? dram_r_data : reg_bus.r_data;
        fwd_r_resp  = rd_dest == dest_dram ? dram_r_resp : reg_bus.r_resp;
        fwd_b_valid = wr_dest == dest_dram ? dram_b_valid : wr_dest == dest_reg && reg_bus.b_valid;
        fwd_b_resp  = wr_dest == dest_dram ? dram_b_resp : reg_bus.b_resp;
    end

    assign fwd_r_ready     = rd_busy && !ib_r_valid;
    assign dram_r_ready    = fwd_r_ready && rd_dest == dest_dram;
    assign reg_bus.r_ready = fwd_r_ready && rd_dest == dest_reg;
    assign fwd_b_ready     = wr_busy && !ib_b_valid;
    assign dram_b_ready    = fwd_b_ready && wr_dest == dest_dram;
    assign reg_bus.b_ready = fwd_b_ready && wr_dest == dest_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            ib_ar_ready      <= 1'b0;
            rd_busy          <= 1'b0;
            rd_dest          <= dest_err;
            dram_ar_valid    <= 1'b0;
            reg_bus.ar_valid <= 1'b0;
            ib_r_valid       <= 1'b0;
        end else begin
            ib_ar_ready <= (!rd_busy || r_hs) && !ar_hs;
            if (ar_hs) begin
                rd_busy          <= 1'b1;
                rd_dest          <= rd_hit;
                rd_addr          <= ib_ar_addr;
                dram_ar_valid    <= rd_hit == dest_dram;
                reg_bus.ar_valid <= rd_hit == dest_reg;
                ib_r_valid       <= rd_hit == dest_err;  // Decode error answered here
                ib_r_data        <= '0;
                ib_r_resp        <= resp_decerr;
            end
            if (dram_ar_valid && dram_ar_ready)
                dram_ar_valid <= 1'b0;
            if (reg_bus.ar_valid && reg_bus.ar_ready)
                reg_bus.ar_valid <= 1'b0;
            if (fwd_r_valid && fwd_r_ready) begin
                ib_r_valid <= 1'b1;
                ib_r_data  <= fwd_r_data;
                ib_r_resp  <= fwd_r_resp;
            end
            if (r_hs) begin
                ib_r_valid <= 1'b0;
                rd_busy    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ready         <= 1'b0;
            wr_busy          <= 1'b0;
            wr_dest          <= dest_err;
            dram_aw_valid    <= 1'b0;
            dram_w_valid     <= 1'b0;
            reg_bus.aw_valid <= 1'b0;
            reg_bus.w_valid  <= 1'b0;
            ib_b_valid       <= 1'b0;
        end else begin
            wr_ready <= (!wr_busy || b_hs) && !aw_hs;
            if (aw_hs) begin
                wr_busy          <= 1'b1;
                wr_dest          <= wr_hit;
                wr_addr          <= ib_aw_addr;
                wr_data          <= ib_w_data;
                wr_strb          <= ib_w_strb;
                dram_aw_valid    <= wr_hit == dest_dram;
                dram_w_valid     <= wr_hit == dest_dram;
                reg_bus.aw_valid <= wr_hit == dest_reg;
                reg_bus.w_valid  <= wr_hit == dest_reg;
                ib_b_valid       <= wr_hit == dest_err;
                ib_b_resp        <= resp_decerr;
            end
            if (dram_aw_valid && dram_aw_ready)
                dram_aw_valid <= 1'b0;
            if (dram_w_valid && dram_w_ready)
                dram_w_valid <= 1'b0;
            if (reg_bus.aw_valid && reg_bus.aw_ready)
                reg_bus.aw_valid <= 1'b0;
            if (reg_bus.w_valid && reg_bus.w_ready)
                reg_bus.w_valid <= 1'b0;
            if (fwd_b_valid && fwd_b_ready) begin
                ib_b_valid <= 1'b1;
                ib_b_resp  <= fwd_b_resp;
            end
            if (b_hs) begin
                ib_b_valid <= 1'b0;
                wr_busy    <= 1'b0;
            end
        end
    end

    // Responses hold until the host takes them
    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        ib_r_valid && !ib_r_ready |=> ib_r_valid && $stable(ib_r_data) && $stable(ib_r_resp));
    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        ib_b_valid && !ib_b_ready |=> ib_b_valid && $stable(ib_b_resp));

    // One outstanding request per channel
    a_rd_single: assert property (@(posedge clk) disable iff (reset) rd_busy |-> !ar_hs);
    a_wr_single: assert property (@(posedge clk) disable iff (reset) wr_busy |-> !aw_hs);

endmodule

//--- hdl/int_regs.sv
`timescale 1ns/10ps

module int_regs #(
    parameter int INTERRUPTS = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [INTERRUPTS-1:0] int_in,
    output logic                  int_out,
    apb_if.slave                  apb
);
    import core_pkg::*;

    logic [INTERRUPTS-1:0] status;
    logic [INTERRUPTS-1:0] enable;
    logic [INTERRUPTS-1:0] status_nxt;
    logic [INTERRUPTS-1:0] enable_nxt;
    logic [INTERRUPTS-1:0] wsel;
    logic [INTERRUPTS-1:0] wbits;
    logic                  wr_en;
    data_t                 wmask;

    assign apb.ready  = apb.sel && apb.enable;  // No wait states
    assign apb.slverr = 1'b0;
    assign wr_en      = apb.sel && apb.enable && apb.write;

    // Byte strobes to bit mask
    always_comb begin
        for (int i = 0; i < 32; i++)
            wmask[i] = apb.strb[i/8];
    end

    assign wsel  = wmask[INTERRUPTS-1:0];
    assign wbits = apb.wdata[INTERRUPTS-1:0] & wsel;

    always_comb begin
        status_nxt = status | int_in;
        enable_nxt = enable;
        if (wr_en) begin
            case (apb.addr[11:0])
                INT_STATUS_OFS: status_nxt = (status & ~wbits) | int_in;  // Set beats clear
                INT_ENABLE_OFS: enable_nxt = (enable & ~wsel) | wbits;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (apb.addr[11:0])
            INT_STATUS_OFS: apb.rdata = data_t'(status);
            INT_ENABLE_OFS: apb.rdata = data_t'(enable);
            INT_RAW_OFS:    apb.rdata = data_t'(int_in);
            default:        apb.rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status  <= '0;
            enable  <= '0;
            int_out <= 1'b0;
        end else begin
            status  <= status_nxt;
            enable  <= enable_nxt;
            int_out <= |(status_nxt & enable_nxt);  // Tracks the registered mask
        end
    end

    a_int_masked: assert property (@(posedge clk) disable iff (reset)
        enable == '0 |-> !int_out);

endmodule

//--- hdl/sp605_core.sv
`timescale 1ns/10ps

module sp605_core #(
    parameter int ADDR       = 32,
    parameter int INTERRUPTS = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    // Inbound host side
    input  logic                  ib_ar_valid,
    output logic                  ib_ar_ready,
    input  logic [ADDR-1:0]       ib_ar_addr,
    output logic                  ib_r_valid,
    input  logic                  ib_r_ready,
    output core_pkg::data_t       ib_r_data,
    output core_pkg::resp_t       ib_r_resp,
    input  logic                  ib_aw_valid,
    output logic                  ib_aw_ready,
    input  logic [ADDR-1:0]       ib_aw_addr,
    input  logic                  ib_w_valid,
    output logic                  ib_w_ready,
    input  core_pkg::data_t       ib_w_data,
    input  core_pkg::strb_t       ib_w_strb,
    output logic                  ib_b_valid,
    input  logic                  ib_b_ready,
    output core_pkg::resp_t       ib_b_resp,
    // DRAM master side
    output logic                  dram_ar_valid,
    input  logic                  dram_ar_ready,
    output logic [ADDR-1:0]       dram_ar_addr,
    input  logic                  dram_r_valid,
    output logic                  dram_r_ready,
    input  core_pkg::data_t       dram_r_data,
    input  core_pkg::resp_t       dram_r_resp,
    output logic                  dram_aw_valid,
    input  logic                  dram_aw_ready,
    output logic [ADDR-1:0]       dram_aw_addr,
    output logic                  dram_w_valid,
    input  logic                  dram_w_ready,
    output core_pkg::data_t       dram_w_data,
    output core_pkg::strb_t       dram_w_strb,
    input  logic                  dram_b_valid,
    output logic                  dram_b_ready,
    input  core_pkg::resp_t       dram_b_resp,
    // Interrupts
    input  logic [INTERRUPTS-1:0] int_in,
    output logic                  int_out
);

    axi_lite_if #(.ADDR(ADDR)) reg_bus ();
    apb_if #(.ADDR(ADDR)) apb_host ();
    apb_if #(.ADDR(ADDR)) apb_page0 ();

    // Port names match the top level one to one
    ib_router #(
        .ADDR(ADDR)
    ) ib_router_i (.*);

    axi_to_apb axi_to_apb_i (
        .clk   (clk),
        .reset (reset),
        .bus   (reg_bus),
        .apb   (apb_host)
    );

    apb_decoder apb_decoder_i (
        .host  (apb_host),
        .page0 (apb_page0)
    );

    int_regs #(
        .INTERRUPTS(INTERRUPTS)
    ) int_regs_i (
        .clk     (clk),
        .reset   (reset),
        .int_in  (int_in),
        .int_out (int_out),
        .apb     (apb_page0)
    );

endmodule

//--- list.f
hdl/core_pkg.sv
hdl/axi_lite_if.sv
hdl/apb_if.sv
hdl/ib_router.sv
hdl/axi_to_apb.sv
hdl/apb_decoder.sv
hdl/int_regs.sv
hdl/sp605_core.sv
test/tb_sp605_core.sv

//--- test/tb_sp605_core.sv
`timescale 1ns/10ps

module tb_sp605_core;
    import core_pkg::*;

    localparam int ADDR       = 32;
    localparam int INTERRUPTS = 3;
    localparam logic [31:0] SEED     = 32'd1;
    localparam logic [31:0] INT_MASK = 32'((1 << INTERRUPTS) - 1);
    localparam logic [31:0] STATUS_ADDR = REG_BASE | 32'(INT_STATUS_OFS);
    localparam logic [31:0] ENABLE_ADDR = REG_BASE | 32'(INT_ENABLE_OFS);
    localparam logic [31:0] RAW_ADDR    = REG_BASE | 32'(INT_RAW_OFS);
    // About 100 transactions of up to 20 cycles each, with ten times margin
    localparam int TXN_COUNT       = 100;
    localparam int TXN_CYCLES      = 20;
    localparam int WATCHDOG_CYCLES = TXN_COUNT * TXN_CYCLES * 10;

    logic clk = 1'b0;
    logic reset;
    logic ib_ar_valid, ib_ar_ready, ib_r_valid, ib_r_ready;
    logic ib_aw_valid, ib_aw_ready, ib_w_valid, ib_w_ready, ib_b_valid, ib_b_ready;
    logic [ADDR-1:0] ib_ar_addr, ib_aw_addr, dram_ar_addr, dram_aw_addr;
    data_t ib_r_data, ib_w_data, dram_r_data, dram_w_data;
    resp_t ib_r_resp, ib_b_resp, dram_r_resp, dram_b_resp;
    strb_t ib_w_strb, dram_w_strb;
    logic dram_ar_valid, dram_ar_ready, dram_r_valid, dram_r_ready;
    logic dram_aw_valid, dram_aw_ready, dram_w_valid, dram_w_ready;
    logic dram_b_valid, dram_b_ready;
    logic [INTERRUPTS-1:0] int_in;
    logic int_out;

    logic [31:0] host_rng = SEED;
    logic        backpressure = 1'b0;
    logic        no_dram = 1'b0;   // Set while only unmapped addresses are used
    logic [31:0] last_rd_addr, last_wr_addr;
    data_t       last_wr_data;
    strb_t       last_wr_strb;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #50 clk = ~clk;

    sp605_core #(.ADDR(ADDR), .INTERRUPTS(INTERRUPTS)) dut_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic value_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("At %0t the bus protocol was broken: %s", $time, msg);
        errors++;
    endtask

    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        ib_r_valid && !ib_r_ready |=> ib_r_valid && $stable(ib_r_data) && $stable(ib_r_resp))
        else protocol_error("read response changed before it was taken");
    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        ib_b_valid && !ib_b_ready |=> ib_b_valid && $stable(ib_b_resp))
        else protocol_error("write response changed before it was taken");
    a_no_dram: assert property (@(posedge clk) disable iff (reset)
        no_dram |-> !dram_ar_valid && !dram_aw_valid)
        else protocol_error("an unmapped address reached the DRAM port");

    // DRAM read side, data is address XOR A5A5_A5A5
    initial begin : dram_read_side
        logic [31:0] rng;
        rng = SEED;
        dram_ar_ready = 1'b0;
        dram_r_valid  = 1'b0;
        dram_r_data   = '0;
        dram_r_resp   = resp_okay;
        forever begin
            @(negedge clk);
            if (dram_ar_valid && !reset) begin
                last_rd_addr  = dram_ar_addr;
                dram_ar_ready = 1'b1;
                @(negedge clk);
                dram_ar_ready = 1'b0;
                rng = xorshift32(rng);
                repeat (rng[1:0]) @(negedge clk);
                dram_r_valid = 1'b1;
                dram_r_data  = last_rd_addr ^ 32'hA5A5_A5A5;
                while (!dram_r_ready) @(negedge clk);
                @(negedge clk);
                dram_r_valid = 1'b0;
            end
        end
    end

    initial begin : dram_write_side
        logic [31:0] rng;
        rng = xorshift32(SEED);
        dram_aw_ready = 1'b0;
        dram_w_ready  = 1'b0;
        dram_b_valid  = 1'b0;
        dram_b_resp   = resp_okay;
        forever begin
            @(negedge clk);
            if (dram_aw_valid && dram_w_valid && !reset) begin
                last_wr_addr  = dram_aw_addr;
                last_wr_data  = dram_w_data;
                last_wr_strb  = dram_w_strb;
                dram_aw_ready = 1'b1;
                dram_w_ready  = 1'b1;
                @(negedge clk);
                dram_aw_ready = 1'b0;
                dram_w_ready  = 1'b0;
                rng = xorshift32(rng);
                repeat (rng[1:0]) @(negedge clk);
                dram_b_valid = 1'b1;
                while (!dram_b_ready) @(negedge clk);
                @(negedge clk);
                dram_b_valid = 1'b0;
            end
        end
    end

    task automatic read_word(input logic [31:0] addr, output data_t data, output resp_t resp);
        logic taken;
        @(negedge clk);
        ib_ar_valid = 1'b1;
        ib_ar_addr  = addr;
        while (!ib_ar_ready) @(negedge clk);
        @(negedge clk);
        ib_ar_valid = 1'b0;
        taken = 1'b0;
        while (!taken) begin
            host_rng   = xorshift32(host_rng);
            ib_r_ready = !backpressure || host_rng[0];
            if (ib_r_valid && ib_r_ready) begin
                data  = ib_r_data;
                resp  = ib_r_resp;
                taken = 1'b1;
            end
            @(negedge clk);
        end
        ib_r_ready = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input data_t data, input strb_t strb,
                              output resp_t resp);
        logic taken;
        @(negedge clk);
        ib_aw_valid = 1'b1;
        ib_w_valid  = 1'b1;
        ib_aw_addr  = addr;
        ib_w_data   = data;
        ib_w_strb   = strb;
        while (!(ib_aw_ready && ib_w_ready)) @(negedge clk);
        @(negedge clk);
        ib_aw_valid = 1'b0;
        ib_w_valid  = 1'b0;
        taken = 1'b0;
        while (!taken) begin
            host_rng   = xorshift32(host_rng);
            ib_b_ready = !backpressure || host_rng[0];
            if (ib_b_valid && ib_b_ready) begin
                resp  = ib_b_resp;
                taken = 1'b1;
            end
            @(negedge clk);
        end
        ib_b_ready = 1'b0;
    endtask

    task automatic check_read(input logic [31:0] addr, input data_t exp_data,
                              input resp_t exp_resp);
        data_t got;
        resp_t resp;
        read_word(addr, got, resp);
        assert (got == exp_data && resp == exp_resp)
            else value_error($sformatf("read %h gave %h/%s, expected %h/%s",
                                       addr, got, resp.name(), exp_data, exp_resp.name()));
    endtask

    task automatic check_write(input logic [31:0] addr, input data_t data, input resp_t exp_resp);
        resp_t resp;
        write_word(addr, data, 4'hF, resp);
        assert (resp == exp_resp)
            else value_error($sformatf("write %h gave %s, expected %s",
                                       addr, resp.name(), exp_resp.name()));
    endtask

    task automatic dram_round_trip(input logic [31:0] addr, input data_t data,
                                   input strb_t strb);
        resp_t resp;
        check_read(addr, addr ^ 32'hA5A5_A5A5, resp_okay);
        assert (last_rd_addr == addr)
            else value_error($sformatf("DRAM read address %h, expected %h", last_rd_addr, addr));
        write_word(addr, data, strb, resp);
        assert (resp == resp_okay)
            else value_error($sformatf("write %h gave %s, expected resp_okay",
                                       addr, resp.name()));
        assert (last_wr_addr == addr && last_wr_data == data && last_wr_strb == strb)
            else value_error($sformatf("DRAM write %h/%h/%h, expected %h/%h/%h",
                                       last_wr_addr, last_wr_data, last_wr_strb,
                                       addr, data, strb));
    endtask

    task automatic check_int_out(input logic exp);
        assert (int_out == exp)
            else value_error($sformatf("int_out is %b, expected %b", int_out, exp));
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errors_at_start)
            tests_failed++;
        $display("test %0d %-24s %s", tests_run, name,
                 errors == errors_at_start ? "ok" : "FAILED");
        errors_at_start = errors;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        logic [31:0] addr;
        logic [7:0]  page;
        reset       = 1'b1;
        ib_ar_valid = 1'b0;
        ib_ar_addr  = '0;
        ib_r_ready  = 1'b0;
        ib_aw_valid = 1'b0;
        ib_aw_addr  = '0;
        ib_w_valid  = 1'b0;
        ib_w_data   = '0;
        ib_w_strb   = '0;
        ib_b_ready  = 1'b0;
        int_in      = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        dram_round_trip(32'h0000_1230, 32'h1234_5678, 4'hF);
        repeat (4) begin
            host_rng = xorshift32(host_rng);
            dram_round_trip(host_rng & DRAM_MASK & ~32'h3, ~host_rng, host_rng[11:8]);
        end
        finish_test("dram window");

        no_dram = 1'b1;
        check_read(32'h4000_0000, '0, resp_decerr);
        check_write(32'h4000_0000, 32'hDEAD_BEEF, resp_decerr);
        check_read(32'h0800_0000, '0, resp_decerr);  // Just above DRAM
        check_write(32'h8010_0000, 32'h0000_0001, resp_decerr);  // Just above registers
        no_dram = 1'b0;
        finish_test("decode error");

        check_write(ENABLE_ADDR, 32'hFFFF_FFFF, resp_okay);
        check_read(ENABLE_ADDR, 32'hFFFF_FFFF & INT_MASK, resp_okay);
        check_write(ENABLE_ADDR, 32'h0000_0000, resp_okay);
        check_read(ENABLE_ADDR, 32'h0, resp_okay);
        @(negedge clk);
        int_in = INTERRUPTS'(5);
        check_read(RAW_ADDR, 32'(int_in), resp_okay);
        int_in = '0;
        check_write(STATUS_ADDR, INT_MASK, resp_okay);
        finish_test("enable and raw");

        for (int k = 0; k < INTERRUPTS; k++) begin
            @(negedge clk);
            int_in[k] = 1'b1;
            @(negedge clk);
            int_in = '0;
            check_read(STATUS_ADDR, 32'h1 << k, resp_okay);  // Sticky after the pulse
            check_int_out(1'b0);
            check_write(ENABLE_ADDR, 32'h1 << k, resp_okay);
            check_int_out(1'b1);
            check_write(STATUS_ADDR, 32'h1 << k, resp_okay);
            check_int_out(1'b0);
            check_read(STATUS_ADDR, 32'h0, resp_okay);
            check_write(ENABLE_ADDR, 32'h0, resp_okay);
        end
        finish_test("interrupt status");

        check_write(ENABLE_ADDR, 32'h5, resp_okay);
        check_read(ENABLE_ADDR | 32'h0000_1000, 32'h0, resp_okay);
        check_write(ENABLE_ADDR | 32'h0000_1000, 32'h2, resp_okay);
        repeat (4) begin
            host_rng = xorshift32(host_rng);
            page = host_rng[7:0] == 8'h00 ? 8'h01 : host_rng[7:0];
            addr = REG_BASE | (32'(page) << 12) | 32'(INT_ENABLE_OFS);
            check_read(addr, 32'h0, resp_okay);
            check_write(addr, host_rng, resp_okay);
        end
        check_read(ENABLE_ADDR, 32'h5, resp_okay);  // Page 0 untouched
        check_write(ENABLE_ADDR, 32'h0, resp_okay);
        finish_test("null pages");

        backpressure = 1'b1;
        repeat (20) begin
            host_rng = xorshift32(host_rng);
            if (host_rng[4]) begin
                dram_round_trip(host_rng & DRAM_MASK & ~32'h3, host_rng ^ 32'h0F0F_0F0F,
                                host_rng[3:0]);
            end else begin
                addr = host_rng;
                check_write(ENABLE_ADDR, addr, resp_okay);
                check_read(ENABLE_ADDR, addr & INT_MASK, resp_okay);
            end
        end
        backpressure = 1'b0;
        finish_test("back-pressure");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
